/* Makefile */
# Verilator simulation of the min-sum LDPC decoder

VERILATOR ?= verilator
TOP       ?= ldpcDecoderTb
FILELIST  ?= ldpcDecoder.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, and pass only when the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)

/* checkNodeUpdate.sv */
`timescale 1ns/1ps
`include "ldpc_config.svh"

module checkNodeUpdate import ldpcPkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         clearMsgs,
  input  logic         stepMsgs,
  input  edgeMsgArrayT varToCheckMsgs,
  output edgeMsgArrayT checkToVarMsgs
);

  edgeMsgArrayT msgNext;

  // min-sum message for one edge
  // magnitude is the smallest absolute value among the other inputs,
  // sign is negative when an odd number of them are negative
  function automatic llrT checkMsg(input int edgeNum, input edgeMsgArrayT vMsgs);
    llrT  others [`LDPC_CHECK_DEGREE-1];
    llrT  mag;
    llrT  absVal;
    logic neg;
    int   n;
    n = 0;
    // gather the other variables on this check
    for (int f = 0; f < `LDPC_NUM_EDGES; f++) begin
      if (f != edgeNum && edgeCheckIdx[f] == edgeCheckIdx[edgeNum]) begin
        others[n] = vMsgs[f];
        n = n + 1;
      end
    end
    // start from the largest positive value
    mag = {1'b0, {(`LDPC_LLR_WIDTH-1){1'b1}}};
    neg = 1'b0;
    for (int k = 0; k < `LDPC_CHECK_DEGREE - 1; k++) begin
      absVal = others[k][`LDPC_LLR_WIDTH-1] ? -others[k] : others[k];
      if (absVal < mag) begin
        mag = absVal;
      end
      // parity of sign bits
      neg = neg ^ others[k][`LDPC_LLR_WIDTH-1];
    end
    return neg ? -mag : mag;
  endfunction

  // all edges in parallel from last round's variable messages
  always_comb begin
    for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
      msgNext[e] = checkMsg(e, varToCheckMsgs);
    end
  end

  // same clear/step timing as the variable side, so both sets
  // move together at one edge
  always_ff @(posedge clk) begin
    if (rst || clearMsgs) begin
      for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
        checkToVarMsgs[e] <= '0;
      end
    end else if (stepMsgs) begin
      checkToVarMsgs <= msgNext;
    end
  end

endmodule

/* decisionSequencer.sv */
`timescale 1ns/1ps
`include "ldpc_config.svh"

module decisionSequencer import ldpcPkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  evidenceArrayT channelEvidence,
  input  edgeMsgArrayT  checkToVarMsgs,
  output evidenceArrayT heldEvidence,
  output logic          clearMsgs,
  output logic          stepMsgs,
  output logic          busy,
  output logic          done,
  output beliefArrayT   beliefs,
  output hardBitsT      decodedBits
);

  // counter wide enough to hold the last iteration index
  localparam int iterWidth = $clog2(`LDPC_ITERATIONS + 1);
  localparam logic [iterWidth-1:0] lastIter = iterWidth'(`LDPC_ITERATIONS - 1);

  seqStateT             state;
  logic [iterWidth-1:0] iterCount;
  beliefArrayT          beliefNext;
  hardBitsT             bitsNext;

  // belief is channel value plus every check message into the variable
  always_comb begin
    for (int v = 0; v < `LDPC_NUM_VARS; v++) begin
      beliefNext[v] = heldEvidence[v];
      for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
        if (edgeVarIdx[e] == v) begin
          beliefNext[v] = beliefNext[v] + checkToVarMsgs[e];
        end
      end
      // zero counts as a one
      bitsNext[v] = (beliefNext[v] <= 0);
    end
  end

  // evidence is captured only when a codeword is accepted
  always_ff @(posedge clk) begin
    if (state == SEQ_IDLE && !busy && start) begin
      heldEvidence <= channelEvidence;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_IDLE;
      iterCount <= '0;
      clearMsgs <= 1'b0;
      stepMsgs <= 1'b0;
      busy <= 1'b0;
      done <= 1'b0;
      decodedBits <= '0;
      for (int v = 0; v < `LDPC_NUM_VARS; v++) begin
        beliefs[v] <= '0;
      end
    end else begin
      done <= 1'b0;
      clearMsgs <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          // busy while idle means the last step just finished
          if (busy) begin
            beliefs <= beliefNext;
            decodedBits <= bitsNext;
            done <= 1'b1;
            busy <= 1'b0;
          end else if (start) begin
            state <= SEQ_RUN;
            clearMsgs <= 1'b1;
            busy <= 1'b1;
            iterCount <= '0;
          end
        end
        SEQ_RUN: begin
          if (clearMsgs) begin
            // first flooding round follows the clear cycle
            stepMsgs <= 1'b1;
          end else if (iterCount == lastIter) begin
            stepMsgs <= 1'b0;
            state <= SEQ_IDLE;
          end else begin
            iterCount <= iterCount + 1'b1;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // done is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("decisionSequencer: done held for two cycles");

endmodule

/* ldpcDecoder.f */
+incdir+.
ldpcPkg.sv
varNodeUpdate.sv
checkNodeUpdate.sv
decisionSequencer.sv
ldpcDecoder.sv
ldpcDecoderTb.sv

/* ldpcDecoder.sv */
`timescale 1ns/1ps

module ldpcDecoder import ldpcPkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  evidenceArrayT channelEvidence,
  output logic          busy,
  output logic          done,
  output beliefArrayT   beliefs,
  output hardBitsT      decodedBits
);

  // evidence held for the whole codeword
  evidenceArrayT heldEvidence;

  // shared strobes to both message sets
  logic clearMsgs;
  logic stepMsgs;

  // the two message sets, each fed from the other's registers
  edgeMsgArrayT varToCheckMsgs;
  edgeMsgArrayT checkToVarMsgs;

  varNodeUpdate varNodes (
    .clk(clk),
    .rst(rst),
    .clearMsgs(clearMsgs),
    .stepMsgs(stepMsgs),
    .heldEvidence(heldEvidence),
    .checkToVarMsgs(checkToVarMsgs),
    .varToCheckMsgs(varToCheckMsgs)
  );

  checkNodeUpdate checkNodes (
    .clk(clk),
    .rst(rst),
    .clearMsgs(clearMsgs),
    .stepMsgs(stepMsgs),
    .varToCheckMsgs(varToCheckMsgs),
    .checkToVarMsgs(checkToVarMsgs)
  );

  // control, iteration count and final beliefs
  decisionSequencer sequencer (
    .clk(clk),
    .rst(rst),
    .start(start),
    .channelEvidence(channelEvidence),
    .checkToVarMsgs(checkToVarMsgs),
    .heldEvidence(heldEvidence),
    .clearMsgs(clearMsgs),
    .stepMsgs(stepMsgs),
    .busy(busy),
    .done(done),
    .beliefs(beliefs),
    .decodedBits(decodedBits)
  );

endmodule

/* ldpcDecoderTb.sv */
`timescale 1ns/1ps
`include "ldpc_config.svh"

module ldpcDecoderTb import ldpcPkg::*; ();

  localparam int numRows = 14;
  // each row takes the start edge, 7 run edges and one hold edge plus some margin
  localparam int watchdogNs = (numRows * (`LDPC_ITERATIONS + 6) + 20) * 4;

  logic          clk;
  logic          rst;
  logic          start;
  evidenceArrayT channelEvidence;
  logic          busy;
  logic          done;
  beliefArrayT   beliefs;
  hardBitsT      decodedBits;

  // stimulus table with one codeword per row
  evidenceArrayT rowEv [numRows];
  bit            rowHasWord [numRows];
  hardBitsT      rowWord [numRows];
  bit            rowPoke [numRows];

  // last completed result that the outputs must hold
  beliefArrayT heldBel;
  hardBitsT    heldBits;

  int          errorCount = 0;
  int          checkCount = 0;
  int unsigned lcgState = 32'h9c9e6768;

  ldpcDecoder uut (
    .clk(clk),
    .rst(rst),
    .start(start),
    .channelEvidence(channelEvidence),
    .busy(busy),
    .done(done),
    .beliefs(beliefs),
    .decodedBits(decodedBits)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // next LCG value folded into -100..+100
  function automatic int randomLlr();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return int'((lcgState >> 8) % 201) - 100;
  endfunction

  // flooding min-sum from zero messages with both sets updated from old values
  function automatic void runModel(input evidenceArrayT ev, output beliefArrayT bel,
                                   output hardBitsT bits);
    int v2c [`LDPC_NUM_EDGES];
    int c2v [`LDPC_NUM_EDGES];
    int nv [`LDPC_NUM_EDGES];
    int nc [`LDPC_NUM_EDGES];
    int mag;
    int absVal;
    bit neg;
    int sum;
    for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
      v2c[e] = 0;
      c2v[e] = 0;
    end
    repeat (`LDPC_ITERATIONS) begin
      for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
        nv[e] = ev[edgeVarIdx[e]];
        mag = 2147483647;
        neg = 1'b0;
        for (int f = 0; f < `LDPC_NUM_EDGES; f++) begin
          // other checks on this variable
          if (f != e && edgeVarIdx[f] == edgeVarIdx[e]) nv[e] = nv[e] + c2v[f];
          // other variables on this check
          if (f != e && edgeCheckIdx[f] == edgeCheckIdx[e]) begin
            absVal = (v2c[f] < 0) ? -v2c[f] : v2c[f];
            if (absVal < mag) mag = absVal;
            if (v2c[f] < 0) neg = ~neg;
          end
        end
        nc[e] = neg ? -mag : mag;
      end
      v2c = nv;
      c2v = nc;
    end
    for (int v = 0; v < `LDPC_NUM_VARS; v++) begin
      sum = ev[v];
      for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
        if (edgeVarIdx[e] == v) sum = sum + c2v[e];
      end
      bel[v] = sum;
      // zero or less decides a one
      bits[v] = (sum <= 0);
    end
  endfunction

  task automatic checkBeliefs(input string name, input beliefArrayT got,
                              input beliefArrayT exp);
    for (int v = 0; v < `LDPC_NUM_VARS; v++) begin
      checkCount++;
      if (got[v] !== exp[v]) begin
        errorCount++;
        $display("Error at %0t: %s[%0d] is %0d, expected %0d", $time, name, v, got[v], exp[v]);
      end
    end
  endtask

  task automatic checkBits(input string name, input hardBitsT got, input hardBitsT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkLogic(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // rows 0 and 1 are directed and the rest are random
  task automatic buildTable();
    for (int r = 0; r < numRows; r++) begin
      rowHasWord[r] = (r < 2);
      rowWord[r] = '0;
      // starts during busy on two of the random rows
      rowPoke[r] = (r == 2 || r == 9);
      for (int v = 0; v < `LDPC_NUM_VARS; v++) begin
        if (r == 0) rowEv[r][v] = 20;
        else if (r == 1) rowEv[r][v] = (v == 3) ? -2 : 10;
        else rowEv[r][v] = randomLlr();
      end
    end
  endtask

  // one codeword entered 1 ns after a rising edge
  task automatic runRow(input int r);
    beliefArrayT expBel;
    hardBitsT    expBits;
    runModel(rowEv[r], expBel, expBits);
    channelEvidence = rowEv[r];
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // busy rises at the start edge itself
    checkLogic("busy", busy, 1'b1);
    checkLogic("done", done, 1'b0);
    // scramble the input so only the latched copy can matter
    for (int v = 0; v < `LDPC_NUM_VARS; v++) channelEvidence[v] = -rowEv[r][v];
    for (int edgeNum = 1; edgeNum <= `LDPC_ITERATIONS + 2; edgeNum++) begin
      @(posedge clk);
      #1;
      if (edgeNum < `LDPC_ITERATIONS + 2) begin
        checkLogic("busy", busy, 1'b1);
        checkLogic("done", done, 1'b0);
        checkBeliefs("beliefs", beliefs, heldBel);
        checkBits("decodedBits", decodedBits, heldBits);
      end
      // stray start sampled at edges 3 to 7
      if (rowPoke[r]) start = (edgeNum >= 2 && edgeNum <= 6);
    end
    checkLogic("done", done, 1'b1);
    checkLogic("busy", busy, 1'b0);
    checkBeliefs("beliefs", beliefs, expBel);
    checkBits("decodedBits", decodedBits, expBits);
    if (rowHasWord[r]) checkBits("decodedBits", decodedBits, rowWord[r]);
    heldBel = expBel;
    heldBits = expBits;
    @(posedge clk);
    #1;
    // done lasts one cycle and the result stays
    checkLogic("done", done, 1'b0);
    checkLogic("busy", busy, 1'b0);
    checkBeliefs("beliefs", beliefs, heldBel);
    checkBits("decodedBits", decodedBits, heldBits);
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    for (int v = 0; v < `LDPC_NUM_VARS; v++) begin
      channelEvidence[v] = '0;
      heldBel[v] = '0;
    end
    heldBits = '0;
    buildTable();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // idle outputs after reset
    checkLogic("busy", busy, 1'b0);
    checkLogic("done", done, 1'b0);
    checkBeliefs("beliefs", beliefs, heldBel);
    checkBits("decodedBits", decodedBits, heldBits);
    for (int r = 0; r < numRows; r++) runRow(r);
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog against a stuck run
  initial begin
    #(watchdogNs);
    $display("timeout: the decoder runs did not finish within %0d ns", watchdogNs);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* ldpcPkg.sv */
`include "ldpc_config.svh"

package ldpcPkg;

  // one signed log-likelihood ratio or message
  typedef logic signed [`LDPC_LLR_WIDTH-1:0] llrT;

  // channel values and beliefs, indexed by variable
  typedef llrT evidenceArrayT [`LDPC_NUM_VARS];
  typedef llrT beliefArrayT [`LDPC_NUM_VARS];

  // one message per edge, same edge order in both directions
  typedef llrT edgeMsgArrayT [`LDPC_NUM_EDGES];

  // bit i is the decision for variable i
  typedef logic [`LDPC_NUM_VARS-1:0] hardBitsT;

  // sequencer states
  typedef enum logic {
    SEQ_IDLE,
    SEQ_RUN
  } seqStateT;

  // edges are ordered by variable first, then by check
  // checks per variable: v0 c0 c3, v1 c1 c4, v2 c0 c2, v3 c1 c3, v4 c0 c2
  // v5 c0 c2 c4, v6 c1 c2 c4, v7 c0 c3 c4, v8 c1 c3 c4, v9 c1 c2 c3
  localparam int edgeVarIdx [`LDPC_NUM_EDGES] = '{
    0, 0, 1, 1, 2, 2, 3, 3, 4, 4,
    5, 5, 5, 6, 6, 6, 7, 7, 7,
    8, 8, 8, 9, 9, 9
  };

  // check node at the other end of each edge
  localparam int edgeCheckIdx [`LDPC_NUM_EDGES] = '{
    0, 3, 1, 4, 0, 2, 1, 3, 0, 2,
    0, 2, 4, 1, 2, 4, 0, 3, 4,
    1, 3, 4, 1, 2, 3
  };

endpackage

/* ldpc_config.svh */
`ifndef LDPC_CONFIG_SVH
`define LDPC_CONFIG_SVH

// code dimensions of the fixed 10-bit, 5-check parity-check code
`define LDPC_NUM_VARS 10
`define LDPC_NUM_CHECKS 5

// one edge per nonzero entry of the parity-check matrix
`define LDPC_NUM_EDGES 25

// every check node touches this many variables
`define LDPC_CHECK_DEGREE 5

// width of channel values, messages and beliefs
`define LDPC_LLR_WIDTH 32

// flooding rounds run for each codeword
`define LDPC_ITERATIONS 5

`endif

/* varNodeUpdate.sv */
`timescale 1ns/1ps
`include "ldpc_config.svh"

module varNodeUpdate import ldpcPkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          clearMsgs,
  input  logic          stepMsgs,
  input  evidenceArrayT heldEvidence,
  input  edgeMsgArrayT  checkToVarMsgs,
  output edgeMsgArrayT  varToCheckMsgs
);

  edgeMsgArrayT msgNext;

  // extrinsic sum for one edge
  // channel value plus every check message into the same variable,
  // leaving out the message that came back along this edge
  function automatic llrT varMsg(input int edgeNum, input evidenceArrayT ev,
                                 input edgeMsgArrayT cMsgs);
    llrT sum;
    sum = ev[edgeVarIdx[edgeNum]];
    for (int f = 0; f < `LDPC_NUM_EDGES; f++) begin
      if (f != edgeNum && edgeVarIdx[f] == edgeVarIdx[edgeNum]) begin
        sum = sum + cMsgs[f];
      end
    end
    return sum;
  endfunction

  // all 25 edges in parallel from last round's check messages
  always_comb begin
    for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
      msgNext[e] = varMsg(e, heldEvidence, checkToVarMsgs);
    end
  end

  // clear starts a codeword from zero messages
  always_ff @(posedge clk) begin
    if (rst || clearMsgs) begin
      for (int e = 0; e < `LDPC_NUM_EDGES; e++) begin
        varToCheckMsgs[e] <= '0;
      end
    end else if (stepMsgs) begin
      varToCheckMsgs <= msgNext;
    end
  end

  // the sequencer must never clear and step in the same cycle
  assert property (@(posedge clk) disable iff (rst) !(clearMsgs && stepMsgs))
    else $error("varNodeUpdate: clearMsgs and stepMsgs both high");

endmodule
